// File: Makefile
# Verilator build and run of the board I/O testbench

VERILATOR ?= verilator
TOP       ?= tb_board_io
FILELIST  ?= board_io_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || (echo "No pass line found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: board_io_top.f
hdl/board_io_pkg.sv
hdl/reg_bus_if.sv
hdl/periph_decoder.sv
hdl/gpio_regs.sv
hdl/uart_tx_unit.sv
hdl/board_io_top.sv
dv/tb_clk_gen.sv
dv/board_io_checker.sv
dv/tb_board_io.sv

// File: dv/board_io_checker.sv
`timescale 1ns/10ps

module board_io_checker (
  input  logic                            i_clk,
  input  logic                            i_arst_n,
  input  logic                            i_req_valid,
  input  logic                            i_req_write,
  input  logic [board_io_pkg::ADDR_W-1:0] i_req_addr,
  input  logic [board_io_pkg::DATA_W-1:0] i_req_wdata,
  input  logic [board_io_pkg::GPIO_W-1:0] i_gpio_in,
  input  logic                            i_rsp_valid,
  input  logic [board_io_pkg::DATA_W-1:0] i_rsp_rdata,
  input  logic                            i_rsp_err,
  input  logic [board_io_pkg::GPIO_W-1:0] i_gpio_out,
  input  logic [board_io_pkg::GPIO_W-1:0] i_gpio_dir,
  input  logic                            i_uart_td,
  output int                              o_err_cnt
);
  import board_io_pkg::*;

  // Start, 8 data and stop bits
  localparam int FRAME_CYC = 10 * UART_DIV;

  logic              live = 1'b0;
  logic [GPIO_W-1:0] m_out = '0;
  logic [GPIO_W-1:0] m_dir = '0;
  logic [GPIO_W-1:0] m_meta = '0;
  logic [GPIO_W-1:0] m_sync = '0;
  logic [7:0]        m_byte = '0;
  // Cycles left until the UART goes idle again
  int                busy_cnt = 0;
  logic              exp_valid = 1'b0;
  logic              exp_err = 1'b0;
  logic [ADDR_W-1:0] exp_addr = '0;
  logic [DATA_W-1:0] exp_rdata = '0;
  int                err_cnt = 0;

  assign o_err_cnt = err_cnt;

  function automatic logic is_mapped(input logic [ADDR_W-1:0] addr);
    return addr inside {GPIO_OUT, GPIO_DIR, GPIO_IN, UART_TXDATA, UART_STATUS};
  endfunction

  function automatic logic [DATA_W-1:0] read_value(input logic [ADDR_W-1:0] addr);
    case (addr)
      GPIO_OUT:    return DATA_W'(m_out);
      GPIO_DIR:    return DATA_W'(m_dir);
      GPIO_IN:     return DATA_W'(m_sync);
      UART_TXDATA: return DATA_W'(m_byte);
      UART_STATUS: return DATA_W'(busy_cnt != 0);
      default:     return '0;
    endcase
  endfunction

  // Line level for bit b of the frame
  function automatic logic frame_bit(input int b);
    if (b == 0) begin
      return 1'b0;
    end else if (b <= 8) begin
      return m_byte[3'(b - 1)];
    end
    return 1'b1;
  endfunction

  task automatic compare(input string name, input logic [DATA_W-1:0] exp,
                         input logic [DATA_W-1:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s expected 0x%0h got 0x%0h at %0t", name, exp, act, $time);
      err_cnt++;
    end
  endtask

  // Model update on the edge where the DUT samples the request
  always @(posedge i_clk) begin
    logic was_busy;
    if (!i_arst_n) begin
      live      = 1'b0;
      m_out     = '0;
      m_dir     = '0;
      m_meta    = '0;
      m_sync    = '0;
      m_byte    = '0;
      busy_cnt  = 0;
      exp_valid = 1'b0;
      exp_err   = 1'b0;
    end else begin
      live      = 1'b1;
      was_busy  = (busy_cnt != 0);
      exp_valid = i_req_valid;
      exp_addr  = i_req_addr;
      exp_err   = i_req_valid && !is_mapped(i_req_addr);
      exp_rdata = read_value(i_req_addr);
      m_sync    = m_meta;
      m_meta    = i_gpio_in;
      if (was_busy) begin
        busy_cnt--;
      end
      if (i_req_valid && i_req_write) begin
        case (i_req_addr)
          GPIO_OUT: m_out = i_req_wdata[GPIO_W-1:0];
          GPIO_DIR: m_dir = i_req_wdata[GPIO_W-1:0];
          UART_TXDATA: begin
            if (!was_busy) begin
              m_byte   = i_req_wdata[7:0];
              busy_cnt = FRAME_CYC;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Outputs are compared mid-cycle, where they are stable
  always @(negedge i_clk) begin
    int k;
    if (live && i_arst_n) begin
      if (exp_valid && !i_rsp_valid) begin
        $display("Response missing for the request to address 0x%0h", exp_addr);
        err_cnt++;
      end else if (!exp_valid && i_rsp_valid) begin
        $display("Response seen without a request in the cycle before at %0t", $time);
        err_cnt++;
      end else if (exp_valid) begin
        compare("o_rsp_rdata", exp_rdata, i_rsp_rdata);
        compare("o_rsp_err", DATA_W'(exp_err), DATA_W'(i_rsp_err));
      end
      compare("o_gpio_out", DATA_W'(m_out), DATA_W'(i_gpio_out));
      compare("o_gpio_dir", DATA_W'(m_dir), DATA_W'(i_gpio_dir));
      if (busy_cnt == 0) begin
        compare("o_uart_td", DATA_W'(1'b1), DATA_W'(i_uart_td));
      end else begin
        k = FRAME_CYC - busy_cnt;
        if (k % UART_DIV == UART_DIV / 2) begin
          compare("o_uart_td", DATA_W'(frame_bit(k / UART_DIV)), DATA_W'(i_uart_td));
        end
      end
    end
  end

endmodule

// File: dv/tb_board_io.sv
`timescale 1ns/10ps

module tb_board_io;
  import board_io_pkg::*;

  localparam int N_GPIO_OPS = 200;
  localparam int N_SYNC     = 40;
  localparam int N_UNMAPPED = 100;
  localparam int N_FRAMES   = 12;
  localparam int N_BUSY     = 4;
  // Twice the expected length of all tests plus slack
  localparam int TIMEOUT_CYCLES = 2 * (20 + N_GPIO_OPS + 6 * N_SYNC + 2 * N_UNMAPPED
                                       + 100 * (N_FRAMES + 2 * N_BUSY)) + 500;

  logic              clk;
  logic              arst_n;
  logic              req_valid = 1'b0;
  logic              req_write = 1'b0;
  logic [ADDR_W-1:0] req_addr = '0;
  logic [DATA_W-1:0] req_wdata = '0;
  logic [GPIO_W-1:0] gpio_in = '0;
  logic              rsp_valid;
  logic [DATA_W-1:0] rsp_rdata;
  logic              rsp_err;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_dir;
  logic              uart_td;
  int                err_cnt;
  integer            seed = 32'h7c906c88;
  int                tests_run = 0;
  int                cycle_cnt = 0;

  tb_clk_gen u_clk_gen (.o_clk(clk), .o_arst_n(arst_n));

  board_io_top u_dut (
    .i_clk(clk), .i_arst_n(arst_n),
    .i_req_valid(req_valid), .i_req_write(req_write),
    .i_req_addr(req_addr), .i_req_wdata(req_wdata),
    .o_rsp_valid(rsp_valid), .o_rsp_rdata(rsp_rdata), .o_rsp_err(rsp_err),
    .i_gpio_in(gpio_in), .o_gpio_out(gpio_out), .o_gpio_dir(gpio_dir),
    .o_uart_td(uart_td)
  );

  board_io_checker u_checker (
    .i_clk(clk), .i_arst_n(arst_n),
    .i_req_valid(req_valid), .i_req_write(req_write),
    .i_req_addr(req_addr), .i_req_wdata(req_wdata), .i_gpio_in(gpio_in),
    .i_rsp_valid(rsp_valid), .i_rsp_rdata(rsp_rdata), .i_rsp_err(rsp_err),
    .i_gpio_out(gpio_out), .i_gpio_dir(gpio_dir), .i_uart_td(uart_td),
    .o_err_cnt(err_cnt)
  );

  task automatic send_req(input logic wr, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data);
    @(negedge clk);
    req_valid = 1'b1;
    req_write = wr;
    req_addr  = addr;
    req_wdata = data;
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    req_valid = 1'b0;
    req_write = 1'b0;
  endtask

  // Single read that returns once the response pulse is seen
  task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    send_req(1'b0, addr, '0);
    idle_cycle();
    while (!rsp_valid) @(negedge clk);
    data = rsp_rdata;
  endtask

  task automatic wait_uart_idle();
    logic [DATA_W-1:0] status;
    do begin
      read_reg(UART_STATUS, status);
    end while (status[0]);
  endtask

  task automatic report_test(input string name, input int errs_before);
    // Past the falling edge where the last response is compared
    @(posedge clk);
    tests_run++;
    $display("Test %0d %s: %0d errors", tests_run, name, err_cnt - errs_before);
  endtask

  task automatic gpio_read_write();
    integer r;
    for (int i = 0; i < N_GPIO_OPS; i++) begin
      r = $random(seed);
      send_req(r[1], r[0] ? GPIO_DIR : GPIO_OUT, $random(seed));
    end
    idle_cycle();
  endtask

  task automatic gpio_input_sync();
    integer r;
    for (int i = 0; i < N_SYNC; i++) begin
      r = $random(seed);
      idle_cycle();
      gpio_in = r[GPIO_W-1:0];
      repeat (3) send_req(1'b0, GPIO_IN, '0);
    end
    idle_cycle();
  endtask

  task automatic unmapped_access();
    integer            r;
    logic [ADDR_W-1:0] a;
    for (int i = 0; i < N_UNMAPPED; i++) begin
      do begin
        r = $random(seed);
        a = r[ADDR_W-1:0];
      end while (a inside {GPIO_OUT, GPIO_DIR, GPIO_IN, UART_TXDATA, UART_STATUS});
      send_req(r[4], a, $random(seed));
    end
    // Read-only registers ignore writes without an error
    send_req(1'b1, GPIO_IN, $random(seed));
    send_req(1'b1, UART_STATUS, $random(seed));
    // Read back to show nothing moved
    send_req(1'b0, GPIO_OUT, '0);
    send_req(1'b0, GPIO_DIR, '0);
    send_req(1'b0, UART_TXDATA, '0);
    idle_cycle();
  endtask

  task automatic uart_frames();
    for (int i = 0; i < N_FRAMES; i++) begin
      send_req(1'b1, UART_TXDATA, $random(seed));
      idle_cycle();
      wait_uart_idle();
    end
  endtask

  task automatic uart_busy_rules();
    integer r;
    for (int i = 0; i < N_BUSY; i++) begin
      r = $random(seed);
      send_req(1'b1, UART_TXDATA, r);
      idle_cycle();
      repeat (r[12:8] + 2) idle_cycle();
      // Dropped while the frame is running
      send_req(1'b1, UART_TXDATA, $random(seed));
      send_req(1'b0, UART_STATUS, '0);
      send_req(1'b0, UART_TXDATA, '0);
      idle_cycle();
      wait_uart_idle();
      send_req(1'b0, UART_TXDATA, '0);
      idle_cycle();
    end
  endtask

  initial begin
    int e0;
    logic [DATA_W-1:0] d;
    @(posedge arst_n);
    repeat (2) idle_cycle();
    e0 = err_cnt;
    read_reg(UART_STATUS, d);
    read_reg(GPIO_OUT, d);
    report_test("reset values", e0);
    e0 = err_cnt;
    gpio_read_write();
    report_test("gpio read/write", e0);
    e0 = err_cnt;
    gpio_input_sync();
    report_test("gpio input sync", e0);
    e0 = err_cnt;
    unmapped_access();
    report_test("unmapped addresses", e0);
    e0 = err_cnt;
    uart_frames();
    report_test("uart frames", e0);
    e0 = err_cnt;
    uart_busy_rules();
    report_test("uart busy rules", e0);
    repeat (4) idle_cycle();
    @(posedge clk);
    $display("Summary: %0d tests run, %0d errors", tests_run, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
      $display("test failed");
      $finish;
    end
  end

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_arst_n
);
  localparam int HALF_PERIOD  = 5;
  localparam int RESET_CYCLES = 5;

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  // Reset leaves on a falling edge, clear of the sampling edge
  initial begin
    o_arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_arst_n = 1'b1;
  end

endmodule

// File: hdl/board_io_pkg.sv
package board_io_pkg;

  // Register data and word address widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 4;

  // Board GPIO pin count
  localparam int GPIO_W = 12;

  // Clock cycles per UART bit
  localparam int UART_DIV = 8;

  // Register word addresses, bit 3 selects the UART side
  typedef enum logic [ADDR_W-1:0] {
    GPIO_OUT    = 4'd0,
    GPIO_DIR    = 4'd1,
    GPIO_IN     = 4'd2,
    UART_TXDATA = 4'd8,
    UART_STATUS = 4'd9
  } reg_addr_e;

  // UART transmitter frame states
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } uart_state_e;

endpackage

// File: hdl/board_io_top.sv
`timescale 1ns/10ps

module board_io_top (
  input  logic                            i_clk,
  input  logic                            i_arst_n,
  // Register request strobe
  input  logic                            i_req_valid,
  input  logic                            i_req_write,
  input  logic [board_io_pkg::ADDR_W-1:0] i_req_addr,
  input  logic [board_io_pkg::DATA_W-1:0] i_req_wdata,
  // Response, one cycle after the request
  output logic                            o_rsp_valid,
  output logic [board_io_pkg::DATA_W-1:0] o_rsp_rdata,
  output logic                            o_rsp_err,
  // GPIO pins split into in, out and direction
  input  logic [board_io_pkg::GPIO_W-1:0] i_gpio_in,
  output logic [board_io_pkg::GPIO_W-1:0] o_gpio_out,
  output logic [board_io_pkg::GPIO_W-1:0] o_gpio_dir,
  // UART transmit line
  output logic                            o_uart_td
);

  reg_bus_if bus_gpio ();
  reg_bus_if bus_uart ();

  periph_decoder u_decoder (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_req_valid (i_req_valid),
    .i_req_write (i_req_write),
    .i_req_addr  (i_req_addr),
    .i_req_wdata (i_req_wdata),
    .bus_gpio    (bus_gpio.host),
    .bus_uart    (bus_uart.host),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp_rdata (o_rsp_rdata),
    .o_rsp_err   (o_rsp_err)
  );

  gpio_regs u_gpio (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .bus        (bus_gpio.periph),
    .i_gpio_in  (i_gpio_in),
    .o_gpio_out (o_gpio_out),
    .o_gpio_dir (o_gpio_dir)
  );

  uart_tx_unit u_uart_tx (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .bus       (bus_uart.periph),
    .o_uart_td (o_uart_td)
  );

endmodule

// File: hdl/gpio_regs.sv
`timescale 1ns/10ps

module gpio_regs (
  input  logic                            i_clk,
  input  logic                            i_arst_n,
  reg_bus_if.periph                       bus,
  input  logic [board_io_pkg::GPIO_W-1:0] i_gpio_in,
  output logic [board_io_pkg::GPIO_W-1:0] o_gpio_out,
  output logic [board_io_pkg::GPIO_W-1:0] o_gpio_dir
);
  import board_io_pkg::*;

  logic [GPIO_W-1:0] gpio_meta;
  logic [GPIO_W-1:0] gpio_sync;

  // Output value and direction, 1 means driven
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_gpio_out <= '0;
      o_gpio_dir <= '0;
    end else if (bus.sel && bus.write) begin
      case (reg_addr_e'({1'b0, bus.addr}))
        GPIO_OUT: o_gpio_out <= bus.wdata[GPIO_W-1:0];
        GPIO_DIR: o_gpio_dir <= bus.wdata[GPIO_W-1:0];
        default:  ;
      endcase
    end
  end

  // Two-flop synchronizer on the pin inputs
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      gpio_meta <= '0;
      gpio_sync <= '0;
    end else begin
      gpio_meta <= i_gpio_in;
      gpio_sync <= gpio_meta;
    end
  end

  always_comb begin
    case (reg_addr_e'({1'b0, bus.addr}))
      GPIO_OUT: bus.rdata = DATA_W'(o_gpio_out);
      GPIO_DIR: bus.rdata = DATA_W'(o_gpio_dir);
      GPIO_IN:  bus.rdata = DATA_W'(gpio_sync);
      default:  bus.rdata = '0;
    endcase
  end

endmodule

// File: hdl/periph_decoder.sv
`timescale 1ns/10ps

module periph_decoder (
  input  logic                             i_clk,
  input  logic                             i_arst_n,
  input  logic                             i_req_valid,
  input  logic                             i_req_write,
  input  logic [board_io_pkg::ADDR_W-1:0]  i_req_addr,
  input  logic [board_io_pkg::DATA_W-1:0]  i_req_wdata,
  reg_bus_if.host                          bus_gpio,
  reg_bus_if.host                          bus_uart,
  output logic                             o_rsp_valid,
  output logic [board_io_pkg::DATA_W-1:0]  o_rsp_rdata,
  output logic                             o_rsp_err
);
  import board_io_pkg::*;

  logic              gpio_hit;
  logic              uart_hit;
  logic [DATA_W-1:0] rsp_rdata_d;

  // Address match against the register map
  always_comb begin
    gpio_hit = 1'b0;
    uart_hit = 1'b0;
    case (reg_addr_e'(i_req_addr))
      GPIO_OUT, GPIO_DIR, GPIO_IN: gpio_hit = 1'b1;
      UART_TXDATA, UART_STATUS:    uart_hit = 1'b1;
      default:                     ;
    endcase
  end

  // Both buses see the request, only the hit side gets the strobe
  assign bus_gpio.sel   = i_req_valid & gpio_hit;
  assign bus_gpio.write = i_req_write;
  assign bus_gpio.addr  = i_req_addr[2:0];
  assign bus_gpio.wdata = i_req_wdata;

  assign bus_uart.sel   = i_req_valid & uart_hit;
  assign bus_uart.write = i_req_write;
  assign bus_uart.addr  = i_req_addr[2:0];
  assign bus_uart.wdata = i_req_wdata;

  // Pre-write read value of the addressed side, zero when unmapped
  always_comb begin
    if (gpio_hit) begin
      rsp_rdata_d = bus_gpio.rdata;
    end else if (uart_hit) begin
      rsp_rdata_d = bus_uart.rdata;
    end else begin
      rsp_rdata_d = '0;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_rsp_valid <= 1'b0;
      o_rsp_err   <= 1'b0;
    end else begin
      o_rsp_valid <= i_req_valid;
      o_rsp_err   <= i_req_valid & ~(gpio_hit | uart_hit);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_req_valid) begin
      o_rsp_rdata <= rsp_rdata_d;
    end
  end

endmodule

// File: hdl/reg_bus_if.sv
`timescale 1ns/10ps

interface reg_bus_if;
  import board_io_pkg::*;

  // One-cycle request strobe into a peripheral
  logic              sel;
  logic              write;
  // Word address inside the peripheral
  logic [2:0]        addr;
  logic [DATA_W-1:0] wdata;
  // Combinational read value for addr
  logic [DATA_W-1:0] rdata;

  modport host (
    output sel, write, addr, wdata,
    input  rdata
  );

  modport periph (
    input  sel, write, addr, wdata,
    output rdata
  );

endinterface

// File: hdl/uart_tx_unit.sv
`timescale 1ns/10ps

module uart_tx_unit (
  input  logic      i_clk,
  input  logic      i_arst_n,
  reg_bus_if.periph bus,
  output logic      o_uart_td
);
  import board_io_pkg::*;

  uart_state_e                   state;
  logic [$clog2(UART_DIV)-1:0]   baud_cnt;
  logic                          baud_done;
  logic [2:0]                    bit_idx;
  logic [7:0]                    shift_reg;
  logic [7:0]                    tx_data;
  logic                          busy;
  logic                          tx_start;

  assign busy      = (state != IDLE);
  assign baud_done = (baud_cnt == ($clog2(UART_DIV))'(UART_DIV - 1));

  // A new frame is taken only while idle
  assign tx_start = bus.sel && bus.write && !busy &&
                    (reg_addr_e'({1'b1, bus.addr}) == UART_TXDATA);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state    <= IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx_data  <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (tx_start) begin
            state    <= START;
            baud_cnt <= '0;
            bit_idx  <= '0;
            tx_data  <= bus.wdata[7:0];
          end
        end
        START: begin
          baud_cnt <= baud_cnt + 1'b1;
          if (baud_done) begin
            state    <= DATA;
            baud_cnt <= '0;
          end
        end
        DATA: begin
          baud_cnt <= baud_cnt + 1'b1;
          if (baud_done) begin
            baud_cnt <= '0;
            bit_idx  <= bit_idx + 1'b1;
            // Last data bit moves on to the stop bit
            if (bit_idx == 3'd7) begin
              state <= STOP;
            end
          end
        end
        STOP: begin
          baud_cnt <= baud_cnt + 1'b1;
          if (baud_done) begin
            state    <= IDLE;
            baud_cnt <= '0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // LSB first, shifted at the end of each data bit
  always_ff @(posedge i_clk) begin
    if (tx_start) begin
      shift_reg <= bus.wdata[7:0];
    end else if (state == DATA && baud_done) begin
      shift_reg <= {1'b0, shift_reg[7:1]};
    end
  end

  always_comb begin
    case (state)
      START:   o_uart_td = 1'b0;
      DATA:    o_uart_td = shift_reg[0];
      default: o_uart_td = 1'b1;
    endcase
  end

  always_comb begin
    case (reg_addr_e'({1'b1, bus.addr}))
      UART_TXDATA: bus.rdata = DATA_W'(tx_data);
      UART_STATUS: bus.rdata = DATA_W'(busy);
      default:     bus.rdata = '0;
    endcase
  end

endmodule
